//--- run.sh
#!/usr/bin/env bash
# build and run the testbench with Verilator
set -u

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing -Wno-fatal --top-module vicTb -f sources.f \
  --Mdir obj_dir -o vicSim
if [ $? -ne 0 ]; then
  echo "build failed"
  exit 1
fi

./obj_dir/vicSim > "$LOG" 2>&1
simStatus=$?
cat "$LOG"

if grep -q "TEST FAILED" "$LOG"; then
  echo "simulation reported a failure"
  exit 1
fi

if [ "$simStatus" -ne 0 ]; then
  echo "simulator exited with status $simStatus"
  exit 1
fi

exit 0

//--- sources.f
+incdir+tb
src/vicPkg.sv
src/regDecode.sv
src/rasterTiming.sv
src/borderColor.sv
src/vicCore.sv
tb/clockGen.sv
tb/vicTb.sv

//--- src/borderColor.sv
`timescale 1ns/10ps

module borderColor (
  input  logic               clk_dot4x,
  input  logic               rst,
  input  vicPkg::vicRegs_t   regs,
  input  vicPkg::rasterPos_t pos,
  output vicPkg::videoOut_t  video
);

  // window edges picked by rsel and csel
  logic [vicPkg::Y_W-1:0] topLine;
  logic [vicPkg::Y_W-1:0] bottomLine;
  logic [vicPkg::X_W-1:0] leftDot;
  logic [vicPkg::X_W-1:0] rightDot;

  // border flip-flops and their next state
  logic vBorder;
  logic hBorder;
  logic vNew;
  logic vNext;
  logic hNext;

  // registered dot
  logic                   strobeQ;
  logic [vicPkg::X_W-1:0] xPosQ;
  logic [vicPkg::Y_W-1:0] yPosQ;
  vicPkg::vicColor_e      colorQ;

  // ----------------------------------------------------------------------
  // border flags
  // ----------------------------------------------------------------------

  assign topLine    = regs.rsel ? vicPkg::BORDER_TOP_RSEL1 : vicPkg::BORDER_TOP_RSEL0;
  assign bottomLine = regs.rsel ? vicPkg::BORDER_BOTTOM_RSEL1 : vicPkg::BORDER_BOTTOM_RSEL0;
  assign leftDot    = regs.csel ? vicPkg::BORDER_LEFT_CSEL1 : vicPkg::BORDER_LEFT_CSEL0;
  assign rightDot   = regs.csel ? vicPkg::BORDER_RIGHT_CSEL1 : vicPkg::BORDER_RIGHT_CSEL0;

  // vertical flag opens only when the display is enabled
  always_comb begin
    vNew = vBorder;
    if (pos.rasterY == topLine && pos.displayEn) begin
      vNew = 1'b0;
    end
    if (pos.rasterY == bottomLine) begin
      vNew = 1'b1;
    end
  end

  // vertical state is only taken over at the left edge
  always_comb begin
    vNext = vBorder;
    hNext = hBorder;
    if (pos.rasterX == leftDot) begin
      vNext = vNew;
      hNext = vNew;
    end
    if (pos.rasterX == rightDot) begin
      hNext = 1'b1;
    end
  end

  // ----------------------------------------------------------------------
  // flags and dot output
  // ----------------------------------------------------------------------

  always_ff @(posedge clk_dot4x) begin
    if (rst) begin
      vBorder <= 1'b1;
      hBorder <= 1'b1;
      strobeQ <= 1'b0;
    end else begin
      strobeQ <= pos.dotTick;
      if (pos.dotTick) begin
        vBorder <= vNext;
        hBorder <= hNext;
      end
    end
  end

  // colour uses the flags as they stand after this dot
  always_ff @(posedge clk_dot4x) begin
    if (pos.dotTick) begin
      xPosQ  <= pos.rasterX;
      yPosQ  <= pos.rasterY;
      colorQ <= (vNext | hNext) ? regs.borderColor : regs.bgColor0;
    end
  end

  assign video.pixelStrobe = strobeQ;
  assign video.xPos        = xPosQ;
  assign video.yPos        = yPosQ;
  assign video.color       = colorQ;

endmodule

//--- src/rasterTiming.sv
`timescale 1ns/10ps

module rasterTiming (
  input  logic               clk_dot4x,
  input  logic               rst,
  input  vicPkg::vicRegs_t   regs,
  output vicPkg::rasterPos_t pos,
  output logic               rasterHit
);

  logic [vicPkg::PHASE_W-1:0] phase;
  logic                       dotTick;
  logic [vicPkg::X_W-1:0]     rasterX;
  logic [vicPkg::Y_W-1:0]     rasterY;
  logic                       displayEn;
  logic                       lineEnd;
  logic                       frameEnd;

  // ----------------------------------------------------------------------
  // dot divider
  // ----------------------------------------------------------------------

  // four clk_dot4x cycles per dot
  always_ff @(posedge clk_dot4x) begin
    if (rst) begin
      phase <= '0;
    end else if (dotTick) begin
      phase <= '0;
    end else begin
      phase <= phase + 1'b1;
    end
  end

  // last cycle of the dot, the beam moves on the edge that ends it
  assign dotTick = (phase == vicPkg::PHASE_LAST);

  // ----------------------------------------------------------------------
  // beam counters
  // ----------------------------------------------------------------------

  assign lineEnd  = (rasterX == vicPkg::RASTER_X_MAX);
  assign frameEnd = (rasterY == vicPkg::RASTER_Y_MAX);

  always_ff @(posedge clk_dot4x) begin
    if (rst) begin
      rasterX <= '0;
      rasterY <= '0;
    end else if (dotTick) begin
      if (lineEnd) begin
        rasterX <= '0;
        // next line, or back to the top
        if (frameEnd) begin
          rasterY <= '0;
        end else begin
          rasterY <= rasterY + 1'b1;
        end
      end else begin
        rasterX <= rasterX + 1'b1;
      end
    end
  end

  // ----------------------------------------------------------------------
  // display enable
  // ----------------------------------------------------------------------

  // den only counts while the beam is on line 48
  // window shuts again on line 248
  always_ff @(posedge clk_dot4x) begin
    if (rst) begin
      displayEn <= 1'b0;
    end else if (dotTick) begin
      if (rasterY == vicPkg::DEN_LINE && regs.den) begin
        displayEn <= 1'b1;
      end
      if (rasterY == vicPkg::DISPLAY_END_LINE) begin
        displayEn <= 1'b0;
      end
    end
  end

  // ----------------------------------------------------------------------
  // raster compare
  // ----------------------------------------------------------------------

  // single cycle pulse on dot 0 of the compare line
  assign rasterHit = dotTick && (rasterX == '0) && (rasterY == regs.rasterCmp);

  assign pos.dotTick   = dotTick;
  assign pos.rasterX   = rasterX;
  assign pos.rasterY   = rasterY;
  assign pos.displayEn = displayEn;

endmodule

//--- src/regDecode.sv
`timescale 1ns/10ps

module regDecode (
  input  logic               clk_dot4x,
  input  logic               rst,
  input  vicPkg::cpuBus_t    bus,
  input  vicPkg::rasterPos_t pos,
  input  logic               rasterHit,
  output vicPkg::vicRegs_t   regs,
  output logic [7:0]         dbo,
  output logic               irq
);

  // ----------------------------------------------------------------------
  // access decode
  // ----------------------------------------------------------------------

  vicPkg::regAddr_e addr;
  logic             rdStb;
  logic             wrStb;
  logic [7:0]       rdMux;

  // raster interrupt latch and its enable
  logic             irst;
  logic             erst;
  logic             irstClr;

  // offset doubles as the opcode
  assign addr  = vicPkg::regAddr_e'(bus.adi);

  // one cycle strobe, no wait states
  assign rdStb = ~bus.ce & bus.rw;
  assign wrStb = ~bus.ce & ~bus.rw;

  // write one to bit 0 of $19 acks the raster interrupt
  assign irstClr = wrStb && (addr == vicPkg::REG_IRQ_STATUS) && bus.dbi[0];

  // ----------------------------------------------------------------------
  // register file
  // ----------------------------------------------------------------------

  always_ff @(posedge clk_dot4x) begin
    if (rst) begin
      regs.rsel        <= 1'b0;
      regs.den         <= 1'b1;
      regs.csel        <= 1'b0;
      regs.rasterCmp   <= '0;
      regs.borderColor <= vicPkg::BLACK;
      regs.bgColor0    <= vicPkg::BLACK;
      erst             <= 1'b0;
    end else if (wrStb) begin
      case (addr)
        vicPkg::REG_CTRL1: begin
          // bit 7 is the ninth bit of the compare line
          regs.rsel         <= bus.dbi[3];
          regs.den          <= bus.dbi[4];
          regs.rasterCmp[8] <= bus.dbi[7];
        end
        vicPkg::REG_RASTER: begin
          regs.rasterCmp[7:0] <= bus.dbi;
        end
        vicPkg::REG_CTRL2: begin
          regs.csel <= bus.dbi[3];
        end
        vicPkg::REG_IRQ_ENABLE: begin
          erst <= bus.dbi[0];
        end
        vicPkg::REG_BORDER: begin
          regs.borderColor <= vicPkg::vicColor_e'(bus.dbi[3:0]);
        end
        vicPkg::REG_BG0: begin
          regs.bgColor0 <= vicPkg::vicColor_e'(bus.dbi[3:0]);
        end
        // $19 handled by the latch below, others ignored
        default: begin
        end
      endcase
    end
  end

  // ----------------------------------------------------------------------
  // raster interrupt
  // ----------------------------------------------------------------------

  // latch sets on a compare match whatever erst says
  // a match in the same cycle as an ack keeps the latch set
  always_ff @(posedge clk_dot4x) begin
    if (rst) begin
      irst <= 1'b0;
    end else if (rasterHit) begin
      irst <= 1'b1;
    end else if (irstClr) begin
      irst <= 1'b0;
    end
  end

  // enabling erst with the latch already set raises irq right away
  assign irq = irst & erst;

  // ----------------------------------------------------------------------
  // read path
  // ----------------------------------------------------------------------

  // unused bits float high like on the real chip
  always_comb begin
    case (addr)
      vicPkg::REG_CTRL1:      rdMux = {pos.rasterY[8], 2'b11, regs.den, regs.rsel, 3'b111};
      vicPkg::REG_RASTER:     rdMux = pos.rasterY[7:0];
      vicPkg::REG_CTRL2:      rdMux = {4'hF, regs.csel, 3'b111};
      vicPkg::REG_IRQ_STATUS: rdMux = {irq, 6'b111111, irst};
      vicPkg::REG_IRQ_ENABLE: rdMux = {7'h7F, erst};
      vicPkg::REG_BORDER:     rdMux = {4'hF, regs.borderColor};
      vicPkg::REG_BG0:        rdMux = {4'hF, regs.bgColor0};
      default:                rdMux = 8'hFF;
    endcase
  end

  // dbo holds the last read value until the next read
  always_ff @(posedge clk_dot4x) begin
    if (rst) begin
      dbo <= 8'hFF;
    end else if (rdStb) begin
      dbo <= rdMux;
    end
  end

endmodule

//--- src/vicCore.sv
`timescale 1ns/10ps

module vicCore (
  input  logic              clk_dot4x,
  input  logic              rst,
  input  vicPkg::cpuBus_t   bus,
  output logic [7:0]        dbo,
  output logic              irq,
  output vicPkg::videoOut_t video
);

  // ----------------------------------------------------------------------
  // stage interconnect
  // ----------------------------------------------------------------------

  // register state out of decode
  vicPkg::vicRegs_t   regs;
  // beam position out of the timing stage
  vicPkg::rasterPos_t pos;
  // compare match, one cycle
  logic               rasterHit;

  // cpu registers, interrupt latch and read data
  regDecode regDecode_i (
    .clk_dot4x (clk_dot4x),
    .rst       (rst),
    .bus       (bus),
    .pos       (pos),
    .rasterHit (rasterHit),
    .regs      (regs),
    .dbo       (dbo),
    .irq       (irq)
  );

  // dot divider, beam counters and display enable
  rasterTiming rasterTiming_i (
    .clk_dot4x (clk_dot4x),
    .rst       (rst),
    .regs      (regs),
    .pos       (pos),
    .rasterHit (rasterHit)
  );

  // border flags and the per dot colour
  borderColor borderColor_i (
    .clk_dot4x (clk_dot4x),
    .rst       (rst),
    .regs      (regs),
    .pos       (pos),
    .video     (video)
  );

endmodule

//--- src/vicPkg.sv
package vicPkg;

  // ----------------------------------------------------------------------
  // beam timing for the PAL 6569
  // ----------------------------------------------------------------------

  // raster position widths
  localparam int X_W = 10;
  localparam int Y_W = 9;

  // clk_dot4x cycles per dot and the phase counter that counts them
  localparam int DOT_DIV = 4;
  localparam int PHASE_W = $clog2(DOT_DIV);
  localparam logic [PHASE_W-1:0] PHASE_LAST = PHASE_W'(DOT_DIV - 1);

  // 504 dots per line, 312 lines per frame
  localparam logic [X_W-1:0] RASTER_X_MAX = X_W'(503);
  localparam logic [Y_W-1:0] RASTER_Y_MAX = Y_W'(311);

  // den is only looked at on line 48
  localparam logic [Y_W-1:0] DEN_LINE = Y_W'(48);
  // display window closes here
  localparam logic [Y_W-1:0] DISPLAY_END_LINE = Y_W'(248);

  // ----------------------------------------------------------------------
  // border window edges
  // ----------------------------------------------------------------------

  // first line inside the window, 25 rows or 24 rows
  localparam logic [Y_W-1:0] BORDER_TOP_RSEL1 = Y_W'(51);
  localparam logic [Y_W-1:0] BORDER_TOP_RSEL0 = Y_W'(55);
  // first line of the lower border
  localparam logic [Y_W-1:0] BORDER_BOTTOM_RSEL1 = Y_W'(251);
  localparam logic [Y_W-1:0] BORDER_BOTTOM_RSEL0 = Y_W'(247);
  // first dot inside the window, 40 columns or 38 columns
  localparam logic [X_W-1:0] BORDER_LEFT_CSEL1 = X_W'(25);
  localparam logic [X_W-1:0] BORDER_LEFT_CSEL0 = X_W'(32);
  // first dot of the right border
  localparam logic [X_W-1:0] BORDER_RIGHT_CSEL1 = X_W'(345);
  localparam logic [X_W-1:0] BORDER_RIGHT_CSEL0 = X_W'(336);

  // ----------------------------------------------------------------------
  // types
  // ----------------------------------------------------------------------

  // register offsets, also used as the decode opcode
  typedef enum logic [5:0] {
    REG_CTRL1      = 6'h11,
    REG_RASTER     = 6'h12,
    REG_CTRL2      = 6'h16,
    REG_IRQ_STATUS = 6'h19,
    REG_IRQ_ENABLE = 6'h1A,
    REG_BORDER     = 6'h20,
    REG_BG0        = 6'h21
  } regAddr_e;

  // palette index
  typedef enum logic [3:0] {
    BLACK, WHITE, RED, CYAN, PURPLE, GREEN, BLUE, YELLOW,
    ORANGE, BROWN, PINK, DARK_GREY, GREY, LIGHT_GREEN, LIGHT_BLUE, LIGHT_GREY
  } vicColor_e;

  // cpu side of the chip, ce is active low, rw high means read
  typedef struct packed {
    logic       ce;
    logic       rw;
    logic [5:0] adi;
    logic [7:0] dbi;
  } cpuBus_t;

  // register state seen by the beam and border logic
  typedef struct packed {
    logic           rsel;
    logic           den;
    logic           csel;
    logic [Y_W-1:0] rasterCmp;
    vicColor_e      borderColor;
    vicColor_e      bgColor0;
  } vicRegs_t;

  // beam position, valid every cycle, dotTick marks the last cycle of a dot
  typedef struct packed {
    logic           dotTick;
    logic [X_W-1:0] rasterX;
    logic [Y_W-1:0] rasterY;
    logic           displayEn;
  } rasterPos_t;

  // one colour index per dot
  typedef struct packed {
    logic           pixelStrobe;
    logic [X_W-1:0] xPos;
    logic [Y_W-1:0] yPos;
    vicColor_e      color;
  } videoOut_t;

endpackage

//--- tb/clockGen.sv
`timescale 1ns/10ps

module clockGen (
  output logic clk_dot4x,
  output logic rst
);

  // 8 ns period, four cycles make one dot
  initial begin
    clk_dot4x = 1'b0;
    forever begin
      #4 clk_dot4x = ~clk_dot4x;
    end
  end

  // reset held for 16 cycles, dropped just after an edge
  initial begin
    rst = 1'b1;
    repeat (16) @(posedge clk_dot4x);
    #1 rst = 1'b0;
  end

endmodule

//--- tb/vicTasks.svh
`ifndef VIC_TASKS_SVH
`define VIC_TASKS_SVH

  // ----------------------------------------------------------------------
  // cpu bus and checking
  // ----------------------------------------------------------------------

  // compare and stop at the first mismatch
  task automatic checkEq(input logic [31:0] actual, input logic [31:0] expected,
                         input string msg);
    if (actual !== expected) begin
      $display("FAIL at %0t: %s, got %0h, expected %0h", $time, msg, actual, expected);
      $display("TEST FAILED");
      $fatal(1, "value mismatch");
    end
  endtask

  // single cycle write, ce low for exactly one clk_dot4x cycle
  task automatic busWrite(input logic [5:0] addr, input logic [7:0] data);
    @(posedge clk_dot4x);
    #1;
    bus.ce  = 1'b0;
    bus.rw  = 1'b0;
    bus.adi = addr;
    bus.dbi = data;
    @(posedge clk_dot4x);
    #1;
    bus.ce = 1'b1;
    bus.rw = 1'b1;
  endtask

  // dbo is registered, valid from the cycle after the access
  task automatic busRead(input logic [5:0] addr, output logic [7:0] data);
    @(posedge clk_dot4x);
    #1;
    bus.ce  = 1'b0;
    bus.rw  = 1'b1;
    bus.adi = addr;
    @(posedge clk_dot4x);
    #1;
    bus.ce = 1'b1;
    data   = dbo;
  endtask

  // 32 bit xorshift
  function automatic logic [31:0] xorshift(input logic [31:0] s);
    logic [31:0] v;
    v = s;
    v = v ^ (v << 13);
    v = v ^ (v >> 17);
    v = v ^ (v << 5);
    return v;
  endfunction

  // ----------------------------------------------------------------------
  // video port
  // ----------------------------------------------------------------------

  // next pixelStrobe, sampled 2 ns after the edge
  // once tracking, every dot must follow the previous one
  task automatic nextStrobe;
    logic [9:0] expX;
    logic [8:0] expY;
    @(posedge clk_dot4x);
    #2;
    while (!video.pixelStrobe) begin
      @(posedge clk_dot4x);
      #2;
    end
    if (seqValid) begin
      expX = (lastX == 10'd503) ? 10'd0 : lastX + 10'd1;
      expY = lastY;
      if (lastX == 10'd503) begin
        expY = (lastY == 9'd311) ? 9'd0 : lastY + 9'd1;
      end
      checkEq(video.xPos, expX, "xPos does not follow the last dot");
      checkEq(video.yPos, expY, "yPos does not follow the last dot");
    end
    lastX    = video.xPos;
    lastY    = video.yPos;
    seqValid = 1'b1;
  endtask

  task automatic waitDot(input int x, input int y);
    nextStrobe();
    while (video.xPos != x || video.yPos != y) begin
      nextStrobe();
    end
  endtask

  // border unless den opened the window on line 48 and the dot is inside it
  function automatic logic borderRef(input int x, input int y, input logic rsel,
                                     input logic csel, input logic den);
    int top;
    int bottom;
    int left;
    int right;
    top    = rsel ? 51 : 55;
    bottom = rsel ? 251 : 247;
    left   = csel ? 25 : 32;
    right  = csel ? 345 : 336;
    return !(den && y >= top && y < bottom && x >= left && x < right);
  endfunction

  // check the current dot and every dot up to endX/endY
  task automatic checkDots(input logic rsel, input logic csel, input logic den,
                           input logic [3:0] bc, input logic [3:0] bg,
                           input int endX, input int endY);
    logic [3:0] expC;
    logic       done;
    done = 1'b0;
    while (!done) begin
      expC = borderRef(video.xPos, video.yPos, rsel, csel, den) ? bc : bg;
      checkEq(video.color, expC,
              $sformatf("colour at dot %0d line %0d", video.xPos, video.yPos));
      done = (video.xPos == endX) && (video.yPos == endY);
      if (!done) begin
        nextStrobe();
      end
    end
  endtask

`endif

//--- tb/vicTb.sv
`timescale 1ns/10ps

module vicTb;

  logic              clk_dot4x;
  logic              rst;
  vicPkg::cpuBus_t   bus;
  logic [7:0]        dbo;
  logic              irq;
  vicPkg::videoOut_t video;

  logic [31:0] seed = 32'h14d03fa5;
  // three checked frames plus almost one to reach frame start, about 2.52M cycles
  int unsigned cycleLimit = 3000000;
  int unsigned cycles = 0;

  // dot tracking for the video port
  logic       seqValid;
  logic [9:0] lastX;
  logic [8:0] lastY;

  // colours left behind by the border test
  logic [3:0] borderCol;
  logic [3:0] bgCol;

  clockGen clockGen_i (
    .clk_dot4x (clk_dot4x),
    .rst       (rst)
  );

  vicCore dut_i (
    .clk_dot4x (clk_dot4x),
    .rst       (rst),
    .bus       (bus),
    .dbo       (dbo),
    .irq       (irq),
    .video     (video)
  );

  `include "vicTasks.svh"

  always @(posedge clk_dot4x) begin
    cycles <= cycles + 1;
    if (cycles >= cycleLimit) begin
      $display("timeout: the tests did not finish within %0d cycles", cycleLimit);
      $display("TEST FAILED");
      $fatal(1, "timeout");
    end
  end

  // ----------------------------------------------------------------------
  // directed tests
  // ----------------------------------------------------------------------

  task automatic regReadback;
    logic [7:0] rd;
    logic [7:0] v;
    busRead(6'h11, rd);
    checkEq(rd, 8'h77, "$11 after reset");
    busRead(6'h16, rd);
    checkEq(rd, 8'hF7, "$16 after reset");
    busRead(6'h1A, rd);
    checkEq(rd, 8'hFE, "$1A after reset");
    busRead(6'h20, rd);
    checkEq(rd, 8'hF0, "$20 after reset");
    busRead(6'h21, rd);
    checkEq(rd, 8'hF0, "$21 after reset");
    // compare line 0 matches the very first dot, latch already set
    busRead(6'h19, rd);
    checkEq(rd, 8'h7F, "$19 after reset");
    repeat (8) begin
      seed = xorshift(seed);
      v    = seed[7:0];
      busWrite(6'h20, v);
      busRead(6'h20, rd);
      checkEq(rd, {4'hF, v[3:0]}, "$20 readback");
      seed = xorshift(seed);
      v    = seed[7:0];
      busWrite(6'h21, v);
      busRead(6'h21, rd);
      checkEq(rd, {4'hF, v[3:0]}, "$21 readback");
      seed = xorshift(seed);
      v    = seed[7:0];
      busWrite(6'h16, v);
      busRead(6'h16, rd);
      checkEq(rd, {4'hF, v[3], 3'b111}, "$16 readback");
      seed = xorshift(seed);
      v    = seed[7:0];
      busWrite(6'h1A, v);
      busRead(6'h1A, rd);
      checkEq(rd, {7'h7F, v[0]}, "$1A readback");
    end
    busRead(6'h3F, rd);
    checkEq(rd, 8'hFF, "unlisted offset $3F");
    busRead(6'h00, rd);
    checkEq(rd, 8'hFF, "unlisted offset $00");
    busWrite(6'h1A, 8'h00);
    busWrite(6'h19, 8'h01);
  endtask

  // dots run through the wrap of line 0, then the line is read back
  task automatic rasterCount;
    logic [7:0] rd;
    seqValid = 1'b0;
    waitDot(200, 1);
    busRead(6'h12, rd);
    checkEq(rd, lastY[7:0], "$12 against yPos");
    busRead(6'h11, rd);
    checkEq(rd[7], lastY[8], "$11 bit 7 against yPos");
  endtask

  task automatic rasterIrq;
    logic [7:0] rd;
    busWrite(6'h1A, 8'h00);
    busWrite(6'h19, 8'h01);
    busWrite(6'h12, 8'd5);
    // ninth compare bit clear, den on
    busWrite(6'h11, 8'h10);
    busWrite(6'h1A, 8'h01);
    checkEq(irq, 1'b0, "irq before the compare line");
    seqValid = 1'b0;
    nextStrobe();
    while (video.xPos != 0 || video.yPos != 5) begin
      checkEq(irq, 1'b0, "irq ahead of dot 0 of line 5");
      nextStrobe();
    end
    checkEq(irq, 1'b1, "irq at dot 0 of line 5");
    busRead(6'h19, rd);
    checkEq(rd, 8'hFF, "$19 with irq pending");
    busWrite(6'h19, 8'h01);
    checkEq(irq, 1'b0, "irq after the ack");
    busRead(6'h19, rd);
    checkEq(rd, 8'h7E, "$19 after the ack");
  endtask

  task automatic irqMasking;
    logic [7:0] rd;
    busWrite(6'h1A, 8'h00);
    busWrite(6'h12, 8'd20);
    seqValid = 1'b0;
    nextStrobe();
    while (video.xPos != 0 || video.yPos != 20) begin
      nextStrobe();
    end
    busRead(6'h19, rd);
    checkEq(rd, 8'h7F, "$19 with a masked match");
    checkEq(irq, 1'b0, "irq while erst is 0");
    // pending latch shows up as soon as erst is set
    busWrite(6'h1A, 8'h01);
    checkEq(irq, 1'b1, "irq right after erst");
    busRead(6'h19, rd);
    checkEq(rd, 8'hFF, "$19 after erst");
    busWrite(6'h19, 8'h01);
    busWrite(6'h1A, 8'h00);
  endtask

  task automatic borderWindow;
    seed      = xorshift(seed);
    borderCol = seed[3:0];
    seed      = xorshift(seed);
    bgCol     = borderCol ^ (seed[3:0] | 4'h1);
    busWrite(6'h20, {4'h0, borderCol});
    busWrite(6'h21, {4'h0, bgCol});
    busWrite(6'h11, 8'h18);
    busWrite(6'h16, 8'h08);
    seqValid = 1'b0;
    waitDot(0, 0);
    checkDots(1'b1, 1'b1, 1'b1, borderCol, bgCol, 503, 310);
    // line 311 is all border, one write per dot gap keeps the dots in step
    busWrite(6'h16, 8'h00);
    nextStrobe();
    checkDots(1'b1, 1'b0, 1'b1, borderCol, bgCol, 0, 311);
    busWrite(6'h11, 8'h10);
    nextStrobe();
    checkDots(1'b0, 1'b0, 1'b1, borderCol, bgCol, 503, 311);
    nextStrobe();
    checkDots(1'b0, 1'b0, 1'b1, borderCol, bgCol, 503, 311);
  endtask

  // den off before line 48, the window never opens
  task automatic displayOff;
    logic [7:0] rd;
    busWrite(6'h11, 8'h00);
    nextStrobe();
    checkEq(video.yPos, 9'd0, "frame start after den off");
    checkDots(1'b0, 1'b0, 1'b0, borderCol, bgCol, 0, 0);
    seed      = xorshift(seed);
    borderCol = bgCol ^ (seed[3:0] | 4'h1);
    busWrite(6'h20, {4'h0, borderCol});
    nextStrobe();
    checkDots(1'b0, 1'b0, 1'b0, borderCol, bgCol, 100, 300);
    // past line 255 the ninth line bit shows in $11 bit 7
    busRead(6'h12, rd);
    checkEq(rd, lastY[7:0], "$12 against yPos on line 300");
    nextStrobe();
    checkDots(1'b0, 1'b0, 1'b0, borderCol, bgCol, 101, 300);
    busRead(6'h11, rd);
    checkEq(rd[7], lastY[8], "$11 bit 7 against yPos on line 300");
    nextStrobe();
    checkDots(1'b0, 1'b0, 1'b0, borderCol, bgCol, 503, 311);
  endtask

  initial begin
    bus      = '0;
    bus.ce   = 1'b1;
    bus.rw   = 1'b1;
    seqValid = 1'b0;
    lastX    = '0;
    lastY    = '0;
    @(negedge rst);
    @(posedge clk_dot4x);
    regReadback();
    rasterCount();
    rasterIrq();
    irqMasking();
    borderWindow();
    displayOff();
    $display("TEST PASSED");
    $finish;
  end

endmodule
